/* source/dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

    // ====================================================================
    // Address layout
    // ====================================================================
    localparam int ADDR_W     = 32;
    localparam int LINE_WORDS = 4;
    // Word select sits just above the byte offset
    localparam int WORD_SEL_W = 2;
    localparam int OFFSET_W   = 4;

    // Upper address bits of the cacheable window 0x80000000..0x807FFFFF
    localparam logic [8:0] CACHEABLE_HI = 9'b1_0000_0000;

    typedef logic [31:0]              word_t;
    typedef logic [LINE_WORDS*32-1:0] line_t;
    typedef logic [3:0]               be_t;

    // Controller states
    typedef enum logic [1:0] {IDLE, WRITEBACK, REFILL, BYPASS} cache_state_e;

    // Opcodes for the Wishbone beat engine
    typedef enum logic [1:0] {
        BUS_NONE,
        BUS_LINE_WRITE,
        BUS_LINE_READ,
        BUS_SINGLE
    } bus_op_e;

    // Replace the enabled bytes of old_w with those of new_w
    function automatic word_t merge_bytes(word_t old_w, word_t new_w, be_t be);
        word_t res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) res[b*8 +: 8] = new_w[b*8 +: 8];
        end
        return res;
    endfunction

endpackage

`default_nettype wire

/* source/cache_array_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface cache_array_if #(parameter int NUM_SETS = 64) ();

    localparam int IDX_W = $clog2(NUM_SETS);
    localparam int TAG_W = dcache_pkg::ADDR_W - IDX_W - dcache_pkg::OFFSET_W;

    // Lookup results from the storage
    logic                  hit;
    dcache_pkg::word_t     hit_word;
    logic                  victim_dirty;
    logic [TAG_W-1:0]      victim_tag;
    dcache_pkg::line_t     victim_line;

    // Update strobes and fill data from the controller
    logic                               hit_write;
    logic                               fill;
    logic [IDX_W-1:0]                   fill_index;
    logic [TAG_W-1:0]                   fill_tag;
    logic [dcache_pkg::WORD_SEL_W-1:0]  fill_word;
    logic                               fill_we;
    dcache_pkg::word_t                  fill_wdata;
    dcache_pkg::be_t                    fill_be;
    dcache_pkg::line_t                  fill_line;

    modport store (
        output hit, hit_word, victim_dirty, victim_tag, victim_line,
        input  hit_write, fill, fill_index, fill_tag, fill_word,
        input  fill_we, fill_wdata, fill_be, fill_line
    );

    modport ctrl (
        input  hit, hit_word, victim_dirty, victim_tag, victim_line,
        output hit_write, fill, fill_index, fill_tag, fill_word,
        output fill_we, fill_wdata, fill_be, fill_line
    );

endinterface

`default_nettype wire

/* source/bus_cmd_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface bus_cmd_if;

    // Command side, set by the controller
    dcache_pkg::bus_op_e   op;
    logic [dcache_pkg::ADDR_W-1:0] base_addr;
    dcache_pkg::word_t     single_wdata;
    logic                  single_we;
    dcache_pkg::be_t       single_be;
    dcache_pkg::line_t     wb_line;

    // Beat status, returned by the engine
    logic                  beat_ack;
    logic                  last_beat;
    dcache_pkg::line_t     line_data;
    dcache_pkg::word_t     rd_word;

    modport master (
        input  op, base_addr, single_wdata, single_we, single_be, wb_line,
        output beat_ack, last_beat, line_data, rd_word
    );

    modport ctrl (
        output op, base_addr, single_wdata, single_we, single_be, wb_line,
        input  beat_ack, last_beat, line_data, rd_word
    );

endinterface

`default_nettype wire

/* source/cache_store.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_store #(
    parameter int NUM_SETS = 64
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [dcache_pkg::ADDR_W-1:0] req_addr_i,
    input  dcache_pkg::word_t             req_wdata_i,
    input  dcache_pkg::be_t               req_be_i,
    cache_array_if.store                  arr
);

    localparam int IDX_W  = $clog2(NUM_SETS);
    localparam int TAG_W  = dcache_pkg::ADDR_W - IDX_W - dcache_pkg::OFFSET_W;
    localparam int BYTE_W = dcache_pkg::OFFSET_W - dcache_pkg::WORD_SEL_W;

    // ====================================================================
    // Storage arrays
    // ====================================================================
    dcache_pkg::line_t data_mem [NUM_SETS];
    logic [TAG_W-1:0]  tag_mem  [NUM_SETS];
    logic [NUM_SETS-1:0] valid_q;
    logic [NUM_SETS-1:0] dirty_q;

    // Live request fields
    logic [IDX_W-1:0]                  idx;
    logic [TAG_W-1:0]                  tag;
    logic [dcache_pkg::WORD_SEL_W-1:0] word_sel;
    dcache_pkg::line_t                 cur_line;
    dcache_pkg::line_t                 hit_line;
    dcache_pkg::line_t                 fill_merged;

    assign idx      = req_addr_i[dcache_pkg::OFFSET_W +: IDX_W];
    assign tag      = req_addr_i[dcache_pkg::ADDR_W-1 -: TAG_W];
    assign word_sel = req_addr_i[BYTE_W +: dcache_pkg::WORD_SEL_W];
    assign cur_line = data_mem[idx];

    // ====================================================================
    // Combinational lookup
    // ====================================================================
    assign arr.hit          = valid_q[idx] && (tag_mem[idx] == tag);
    assign arr.hit_word     = cur_line[{word_sel, 5'd0} +: 32];
    assign arr.victim_dirty = valid_q[idx] && dirty_q[idx];
    assign arr.victim_tag   = tag_mem[idx];
    // Writeback source is addressed by the latched index
    assign arr.victim_line  = data_mem[arr.fill_index];

    always_comb begin
        // Write hit, live data merged into the selected word
        hit_line = cur_line;
        hit_line[{word_sel, 5'd0} +: 32] =
            dcache_pkg::merge_bytes(arr.hit_word, req_wdata_i, req_be_i);

        // Refill line, write-allocate data merged in
        fill_merged = arr.fill_line;
        if (arr.fill_we) begin
            fill_merged[{arr.fill_word, 5'd0} +: 32] = dcache_pkg::merge_bytes(
                arr.fill_line[{arr.fill_word, 5'd0} +: 32], arr.fill_wdata, arr.fill_be);
        end
    end

    // ====================================================================
    // Array updates
    // ====================================================================
    always_ff @(posedge clk) begin
        if (arr.fill) begin
            data_mem[arr.fill_index] <= fill_merged;
            tag_mem[arr.fill_index]  <= arr.fill_tag;
        end else if (arr.hit_write) begin
            data_mem[idx] <= hit_line;
        end
    end

    // All lines invalid and clean out of reset
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (arr.fill) begin
            valid_q[arr.fill_index] <= 1'b1;
            // Dirty only when a write allocated the line
            dirty_q[arr.fill_index] <= arr.fill_we;
        end else if (arr.hit_write) begin
            dirty_q[idx] <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* source/cache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl #(
    parameter int NUM_SETS = 64
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [dcache_pkg::ADDR_W-1:0] req_addr_i,
    input  dcache_pkg::word_t             req_wdata_i,
    input  dcache_pkg::be_t               req_be_i,
    input  logic                          req_we_i,
    input  logic                          req_valid_i,
    output dcache_pkg::word_t             resp_data_o,
    output logic                          req_ready_o,
    cache_array_if.ctrl                   arr,
    bus_cmd_if.ctrl                       bus
);

    localparam int IDX_W  = $clog2(NUM_SETS);
    localparam int TAG_W  = dcache_pkg::ADDR_W - IDX_W - dcache_pkg::OFFSET_W;
    localparam int BYTE_W = dcache_pkg::OFFSET_W - dcache_pkg::WORD_SEL_W;

    dcache_pkg::cache_state_e state_q;
    dcache_pkg::cache_state_e state_d;

    // Request held for the whole miss or bypass
    logic [dcache_pkg::ADDR_W-1:0] addr_q;
    dcache_pkg::word_t             wdata_q;
    dcache_pkg::be_t               be_q;
    logic                          we_q;
    logic [TAG_W-1:0]              vtag_q;

    logic cacheable;
    logic cached_hit;
    logic [dcache_pkg::WORD_SEL_W-1:0] word_q;

    assign cacheable  = req_addr_i[dcache_pkg::ADDR_W-1 -: $bits(dcache_pkg::CACHEABLE_HI)]
                        == dcache_pkg::CACHEABLE_HI;
    assign cached_hit = cacheable && arr.hit;
    assign word_q     = addr_q[BYTE_W +: dcache_pkg::WORD_SEL_W];

    // ====================================================================
    // State machine
    // ====================================================================
    always_comb begin
        state_d = state_q;
        case (state_q)
            dcache_pkg::IDLE: begin
                if (req_valid_i && !cacheable) begin
                    state_d = dcache_pkg::BYPASS;
                end else if (req_valid_i && !arr.hit) begin
                    // Dirty victim goes out before the refill
                    state_d = arr.victim_dirty ? dcache_pkg::WRITEBACK : dcache_pkg::REFILL;
                end
            end
            dcache_pkg::WRITEBACK: if (bus.last_beat) state_d = dcache_pkg::REFILL;
            default:               if (bus.last_beat) state_d = dcache_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= dcache_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Capture on the edge that leaves IDLE
    always_ff @(posedge clk) begin
        if (state_q == dcache_pkg::IDLE && req_valid_i && !cached_hit) begin
            addr_q  <= req_addr_i;
            wdata_q <= req_wdata_i;
            be_q    <= req_be_i;
            we_q    <= req_we_i;
            vtag_q  <= arr.victim_tag;
        end
    end

    // ====================================================================
    // Storage and bus commands
    // ====================================================================
    assign arr.hit_write  = state_q == dcache_pkg::IDLE && req_valid_i && cached_hit && req_we_i;
    assign arr.fill       = state_q == dcache_pkg::REFILL && bus.last_beat;
    assign arr.fill_index = addr_q[dcache_pkg::OFFSET_W +: IDX_W];
    assign arr.fill_tag   = addr_q[dcache_pkg::ADDR_W-1 -: TAG_W];
    assign arr.fill_word  = word_q;
    assign arr.fill_we    = we_q;
    assign arr.fill_wdata = wdata_q;
    assign arr.fill_be    = be_q;
    assign arr.fill_line  = bus.line_data;

    assign bus.single_wdata = wdata_q;
    assign bus.single_we    = we_q;
    assign bus.single_be    = be_q;
    assign bus.wb_line      = arr.victim_line;

    always_comb begin
        bus.op        = dcache_pkg::BUS_NONE;
        bus.base_addr = addr_q;
        case (state_q)
            dcache_pkg::WRITEBACK: begin
                bus.op        = dcache_pkg::BUS_LINE_WRITE;
                // Old line address from victim tag and latched index
                bus.base_addr = {vtag_q, arr.fill_index, {dcache_pkg::OFFSET_W{1'b0}}};
            end
            dcache_pkg::REFILL: begin
                bus.op        = dcache_pkg::BUS_LINE_READ;
                bus.base_addr = {addr_q[dcache_pkg::ADDR_W-1:dcache_pkg::OFFSET_W],
                                 {dcache_pkg::OFFSET_W{1'b0}}};
            end
            dcache_pkg::BYPASS: bus.op = dcache_pkg::BUS_SINGLE;
            default: ;
        endcase
    end

    // ====================================================================
    // CPU response
    // ====================================================================
    always_comb begin
        req_ready_o = 1'b0;
        resp_data_o = '0;
        case (state_q)
            dcache_pkg::IDLE: begin
                if (req_valid_i && cached_hit) begin
                    req_ready_o = 1'b1;
                    resp_data_o = req_we_i ? '0 : arr.hit_word;
                end
            end
            dcache_pkg::REFILL: begin
                // Requested word, last beat included
                req_ready_o = bus.last_beat;
                resp_data_o = we_q ? '0 : bus.line_data[{word_q, 5'd0} +: 32];
            end
            dcache_pkg::BYPASS: begin
                req_ready_o = bus.last_beat;
                resp_data_o = we_q ? '0 : bus.rd_word;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* source/wb_beat_master.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_beat_master (
    input  logic              clk,
    input  logic              rst,
    bus_cmd_if.master         bus,
    input  dcache_pkg::word_t wb_dat_i,
    input  logic              wb_ack_i,
    output dcache_pkg::word_t wb_adr_o,
    output dcache_pkg::word_t wb_dat_o,
    output dcache_pkg::be_t   wb_sel_o,
    output logic              wb_we_o,
    output logic              wb_stb_o,
    output logic              wb_cyc_o
);

    logic [dcache_pkg::WORD_SEL_W-1:0] beat_q;
    dcache_pkg::line_t                 line_q;
    dcache_pkg::line_t                 line_now;
    logic                              active;

    assign active        = bus.op != dcache_pkg::BUS_NONE;
    assign bus.beat_ack  = active && wb_ack_i;
    assign bus.last_beat = bus.beat_ack && (bus.op == dcache_pkg::BUS_SINGLE ||
                           beat_q == dcache_pkg::WORD_SEL_W'(dcache_pkg::LINE_WORDS - 1));
    assign bus.rd_word   = wb_dat_i;

    // Beat counter, restarts on every new operation
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            beat_q <= '0;
        end else if (!active || bus.last_beat) begin
            beat_q <= '0;
        end else if (bus.beat_ack) begin
            beat_q <= beat_q + 1'b1;
        end
    end

    // Refill words collected by beat
    always_ff @(posedge clk) begin
        if (bus.op == dcache_pkg::BUS_LINE_READ && bus.beat_ack) begin
            line_q[{beat_q, 5'd0} +: 32] <= wb_dat_i;
        end
    end

    always_comb begin
        line_now = line_q;
        line_now[{beat_q, 5'd0} +: 32] = wb_dat_i;
    end
    assign bus.line_data = line_now;

    // ====================================================================
    // Wishbone fields per opcode
    // ====================================================================
    assign wb_cyc_o = active;
    assign wb_stb_o = active;

    always_comb begin
        // Line beats walk word addresses from the line base
        wb_adr_o = {bus.base_addr[dcache_pkg::ADDR_W-1:dcache_pkg::OFFSET_W], beat_q, 2'b00};
        wb_dat_o = '0;
        wb_sel_o = '1;
        wb_we_o  = 1'b0;
        case (bus.op)
            dcache_pkg::BUS_LINE_WRITE: begin
                wb_dat_o = bus.wb_line[{beat_q, 5'd0} +: 32];
                wb_we_o  = 1'b1;
            end
            dcache_pkg::BUS_SINGLE: begin
                wb_adr_o = bus.base_addr;
                wb_dat_o = bus.single_wdata;
                wb_sel_o = bus.single_be;
                wb_we_o  = bus.single_we;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* source/dcache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_top #(
    parameter int NUM_SETS = 64
) (
    input  logic                          clk,
    input  logic                          rst,

    // CPU request port
    input  logic [dcache_pkg::ADDR_W-1:0] req_addr_i,
    input  dcache_pkg::word_t             req_wdata_i,
    input  dcache_pkg::be_t               req_be_i,
    input  logic                          req_we_i,
    input  logic                          req_valid_i,
    output dcache_pkg::word_t             resp_data_o,
    output logic                          req_ready_o,

    // Wishbone master port
    output dcache_pkg::word_t             wb_adr_o,
    output dcache_pkg::word_t             wb_dat_o,
    output dcache_pkg::be_t               wb_sel_o,
    output logic                          wb_we_o,
    output logic                          wb_stb_o,
    output logic                          wb_cyc_o,
    input  dcache_pkg::word_t             wb_dat_i,
    input  logic                          wb_ack_i
);

    // ====================================================================
    // Internal links
    // ====================================================================
    cache_array_if #(.NUM_SETS(NUM_SETS)) arr_if ();
    bus_cmd_if bus_if ();

    // Lookup and storage
    cache_store #(.NUM_SETS(NUM_SETS)) store_inst (
        .clk         (clk),
        .rst         (rst),
        .req_addr_i  (req_addr_i),
        .req_wdata_i (req_wdata_i),
        .req_be_i    (req_be_i),
        .arr         (arr_if.store)
    );

    // Miss handling and CPU response
    cache_ctrl #(.NUM_SETS(NUM_SETS)) ctrl_inst (
        .clk         (clk),
        .rst         (rst),
        .req_addr_i  (req_addr_i),
        .req_wdata_i (req_wdata_i),
        .req_be_i    (req_be_i),
        .req_we_i    (req_we_i),
        .req_valid_i (req_valid_i),
        .resp_data_o (resp_data_o),
        .req_ready_o (req_ready_o),
        .arr         (arr_if.ctrl),
        .bus         (bus_if.ctrl)
    );

    // Bus beats
    wb_beat_master beat_inst (
        .clk      (clk),
        .rst      (rst),
        .bus      (bus_if.master),
        .wb_dat_i (wb_dat_i),
        .wb_ack_i (wb_ack_i),
        .wb_adr_o (wb_adr_o),
        .wb_dat_o (wb_dat_o),
        .wb_sel_o (wb_sel_o),
        .wb_we_o  (wb_we_o),
        .wb_stb_o (wb_stb_o),
        .wb_cyc_o (wb_cyc_o)
    );

endmodule

`default_nettype wire

/* testbench/dcache_monitor.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_monitor (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] req_addr_i,
    input  logic [3:0]  req_be_i,
    input  logic        req_we_i,
    input  logic        req_valid_i,
    input  logic [31:0] resp_data_i,
    input  logic        req_ready_i,
    input  logic [31:0] wb_adr_i,
    input  logic [31:0] wb_wdata_i,
    input  logic [3:0]  wb_sel_i,
    input  logic        wb_we_i,
    input  logic        wb_stb_i,
    input  logic        wb_cyc_i,
    input  logic        wb_ack_i,
    input  logic [31:0] exp_data_i,
    input  int          exp_beats_i,
    output int          data_errors_o,
    output int          bus_errors_o
);

    int          data_errs  = 0;
    int          bus_errs   = 0;
    // Acknowledged beats of the current request
    int          beat_n     = 0;
    logic        seen_req   = 1'b0;
    logic        exp_we;
    logic [31:0] group_base = '0;

    // Bus fields of the previous edge while a beat waited
    logic        prev_wait  = 1'b0;
    logic [31:0] prev_adr   = '0;
    logic [31:0] prev_dat   = '0;
    logic [3:0]  prev_sel   = '0;
    logic        prev_we    = 1'b0;

    assign data_errors_o = data_errs;
    assign bus_errors_o  = bus_errs;

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp, input bit on_data);
        $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
        if (on_data) begin
            data_errs++;
        end else begin
            bus_errs++;
        end
    endtask

    task automatic bus_fault(input string what);
        $display("Bus error at %0t ns: %s", $time, what);
        bus_errs++;
    endtask

    // ====================================================================
    // Sampled on the rising edge, inputs move only on the falling edge
    // ====================================================================
    always @(posedge clk) begin
        // Ready and bus quiet through reset and up to the first request
        if (!seen_req) begin
            if (req_ready_i) report_mismatch("req_ready_o", req_ready_i, 0, 0);
            if (wb_stb_i) report_mismatch("wb_stb_o", wb_stb_i, 0, 0);
            if (wb_cyc_i) report_mismatch("wb_cyc_o", wb_cyc_i, 0, 0);
            if (wb_we_i) report_mismatch("wb_we_o", wb_we_i, 0, 0);
        end
        if (req_valid_i && !rst) seen_req = 1'b1;
        if (rst) beat_n = 0;

        if (wb_cyc_i != wb_stb_i) report_mismatch("wb_cyc_o", wb_cyc_i, wb_stb_i, 0);
        // Fields held until the beat is acknowledged
        if (prev_wait && wb_stb_i && (wb_adr_i != prev_adr || wb_wdata_i != prev_dat ||
                                      wb_sel_i != prev_sel || wb_we_i != prev_we)) begin
            bus_fault("address, data, select or we changed before ack");
        end
        if (wb_stb_i && !req_valid_i) bus_fault("strobe with no request pending");
        if (wb_stb_i && req_valid_i && exp_beats_i == 0) begin
            bus_fault("strobe during a request that should hit the cache");
        end

        if (wb_stb_i && wb_ack_i) begin
            if (exp_beats_i == 1) begin
                // Single beat carries the request as it is
                if (wb_adr_i != req_addr_i) report_mismatch("wb_adr_o", wb_adr_i, req_addr_i, 0);
                if (wb_sel_i != req_be_i) report_mismatch("wb_sel_o", wb_sel_i, req_be_i, 0);
                if (wb_we_i != req_we_i) report_mismatch("wb_we_o", wb_we_i, req_we_i, 0);
            end else begin
                // Line beats, writeback group first on a dirty miss
                exp_we = exp_beats_i == 8 && beat_n < 4;
                if (beat_n % 4 == 0) begin
                    group_base = wb_adr_i;
                    if (wb_adr_i[3:0] != 4'h0) begin
                        report_mismatch("wb_adr_o", wb_adr_i, {wb_adr_i[31:4], 4'h0}, 0);
                    end
                end else if (wb_adr_i != group_base + 32'(4 * (beat_n % 4))) begin
                    report_mismatch("wb_adr_o", wb_adr_i, group_base + 32'(4 * (beat_n % 4)), 0);
                end
                if (!exp_we && wb_adr_i[31:4] != req_addr_i[31:4]) begin
                    report_mismatch("wb_adr_o", wb_adr_i, {req_addr_i[31:4], wb_adr_i[3:0]}, 0);
                end
                if (wb_sel_i != 4'hF) report_mismatch("wb_sel_o", wb_sel_i, 4'hF, 0);
                if (wb_we_i != exp_we) report_mismatch("wb_we_o", wb_we_i, exp_we, 0);
            end
            beat_n++;
        end

        // Handshake closes the request
        if (req_ready_i) begin
            if (!req_valid_i) bus_fault("ready given with no request pending");
            if (beat_n != exp_beats_i) begin
                report_mismatch("wb_ack_i beat count", 32'(beat_n), 32'(exp_beats_i), 0);
            end
            if (resp_data_i !== exp_data_i) begin
                report_mismatch("resp_data_o", resp_data_i, exp_data_i, 1);
            end
            beat_n = 0;
        end

        prev_wait = wb_stb_i && !wb_ack_i;
        prev_adr  = wb_adr_i;
        prev_dat  = wb_wdata_i;
        prev_sel  = wb_sel_i;
        prev_we   = wb_we_i;
    end

endmodule

`default_nettype wire

/* testbench/tb_dcache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_dcache_top;

    localparam int          NUM_SETS  = 64;
    localparam int          MAX_REQ   = 32;
    // op, address, write data, byte enables, expected data, bus beats
    localparam int          COLS      = 6;
    localparam int          RESET_CYC = 16;
    localparam logic [31:0] FILL_XOR  = 32'h5A5A5A5A;
    localparam logic [31:0] END_MARK  = 32'hFFFFFFFF;

    logic        clk = 1'b0;
    logic        rst;
    logic [31:0] req_addr;
    logic [31:0] req_wdata;
    logic [3:0]  req_be;
    logic        req_we;
    logic        req_valid;
    logic [31:0] resp_data;
    logic        req_ready;
    logic [31:0] wb_adr;
    logic [31:0] wb_wdata;
    logic [31:0] wb_rdata = '0;
    logic [3:0]  wb_sel;
    logic        wb_we;
    logic        wb_stb;
    logic        wb_cyc;
    logic        wb_ack = 1'b0;

    logic [31:0] exp_data;
    int          exp_beats;
    int          data_errors;
    int          bus_errors;
    int          other_errors = 0;

    logic [31:0] vectors [MAX_REQ*COLS];
    // Sparse memory holding only written words
    logic [31:0] mem [logic [31:0]];
    logic [31:0] rng_state    = 32'd77359;
    int          ack_wait     = 0;
    bit          beat_pending = 1'b0;
    int          num_req      = 0;
    bit          loaded       = 1'b0;

    always #50 clk = ~clk;

    dcache_top #(.NUM_SETS(NUM_SETS)) dcache_top_inst (
        .clk         (clk),
        .rst         (rst),
        .req_addr_i  (req_addr),
        .req_wdata_i (req_wdata),
        .req_be_i    (req_be),
        .req_we_i    (req_we),
        .req_valid_i (req_valid),
        .resp_data_o (resp_data),
        .req_ready_o (req_ready),
        .wb_adr_o    (wb_adr),
        .wb_dat_o    (wb_wdata),
        .wb_sel_o    (wb_sel),
        .wb_we_o     (wb_we),
        .wb_stb_o    (wb_stb),
        .wb_cyc_o    (wb_cyc),
        .wb_dat_i    (wb_rdata),
        .wb_ack_i    (wb_ack)
    );

    dcache_monitor monitor_inst (
        .clk (clk), .rst (rst),
        .req_addr_i (req_addr), .req_be_i (req_be), .req_we_i (req_we),
        .req_valid_i (req_valid), .resp_data_i (resp_data), .req_ready_i (req_ready),
        .wb_adr_i (wb_adr), .wb_wdata_i (wb_wdata), .wb_sel_i (wb_sel), .wb_we_i (wb_we),
        .wb_stb_i (wb_stb), .wb_cyc_i (wb_cyc), .wb_ack_i (wb_ack),
        .exp_data_i (exp_data), .exp_beats_i (exp_beats),
        .data_errors_o (data_errors), .bus_errors_o (bus_errors)
    );

    // xorshift32 step for the ack delay
    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // Unwritten words read as address XOR fill pattern
    function automatic logic [31:0] read_word(input logic [31:0] addr);
        logic [31:0] wa;
        wa = {addr[31:2], 2'b00};
        if (mem.exists(wa)) return mem[wa];
        return wa ^ FILL_XOR;
    endfunction

    task automatic write_word(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] sel);
        logic [31:0] w;
        int          b;
        w = read_word(addr);
        for (b = 0; b < 4; b++) begin
            if (sel[b]) w[b*8 +: 8] = data[b*8 +: 8];
        end
        mem[{addr[31:2], 2'b00}] = w;
    endtask

    // ====================================================================
    // Wishbone slave model with 0 to 3 wait cycles per beat
    // ====================================================================
    always @(negedge clk) begin
        if (rst) begin
            wb_ack       <= 1'b0;
            beat_pending = 1'b0;
        end else if (wb_ack) begin
            // Beat taken at the last rising edge
            wb_ack       <= 1'b0;
            beat_pending = 1'b0;
        end else if (wb_stb) begin
            if (!beat_pending) begin
                ack_wait     = int'(next_random() % 4);
                beat_pending = 1'b1;
            end
            if (ack_wait == 0) begin
                if (wb_we) begin
                    write_word(wb_adr, wb_wdata, wb_sel);
                end else begin
                    wb_rdata <= read_word(wb_adr);
                end
                wb_ack <= 1'b1;
            end else begin
                ack_wait--;
            end
        end
    end

    // ====================================================================
    // Stimulus from the data file
    // ====================================================================
    initial begin
        int k;
        int base;
        rst       = 1'b1;
        req_addr  = '0;
        req_wdata = '0;
        req_be    = '0;
        req_we    = 1'b0;
        req_valid = 1'b0;
        exp_data  = '0;
        exp_beats = 0;
        for (k = 0; k < MAX_REQ*COLS; k++) begin
            vectors[k] = END_MARK;
        end
        $readmemh("testbench/dcache_testdata.txt", vectors);
        while (num_req < MAX_REQ && vectors[num_req*COLS] != END_MARK) begin
            num_req++;
        end
        if (num_req == 0) begin
            $display("No requests could be read from the data file");
            other_errors++;
        end
        loaded = 1'b1;

        repeat (RESET_CYC) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (k = 0; k < num_req; k++) begin
            base = k * COLS;
            @(negedge clk);
            req_we    = vectors[base][0];
            req_addr  = vectors[base+1];
            req_wdata = vectors[base+2];
            req_be    = vectors[base+3][3:0];
            exp_data  = vectors[base+4];
            exp_beats = int'(vectors[base+5]);
            req_valid = 1'b1;
            // Hold the request until ready is seen at a rising edge
            @(posedge clk);
            while (!req_ready) @(posedge clk);
            @(negedge clk);
            req_valid = 1'b0;
        end

        repeat (2) @(posedge clk);
        @(negedge clk);
        $display("Error counts: data %0d, bus %0d, other %0d",
                 data_errors, bus_errors, other_errors);
        if (data_errors + bus_errors + other_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // Watchdog sized for 12 beats of 5 cycles per request
    initial begin
        wait (loaded);
        repeat (RESET_CYC + num_req * 12 * 5 + 100) @(posedge clk);
        $display("Simulation hung, %0d requests did not finish in time", num_req);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/dcache_testdata.txt */
// op(0 read, 1 write) address write_data byte_enables expected_read_data bus_beats
// Unwritten memory reads as address ^ 5A5A5A5A, writes expect zero data
0 80000010 00000000 F DA5A5A4A 4
0 80000010 00000000 F DA5A5A4A 0
0 80000014 00000000 F DA5A5A4E 0
1 80000014 11223344 3 00000000 0
0 80000014 00000000 F DA5A3344 0
1 80000128 AABBCCDD C 00000000 4
0 80000128 00000000 F AABB5B72 0
0 8000012C 00000000 F DA5A5B76 0
0 80000418 00000000 F DA5A5E42 8
0 80000014 00000000 F DA5A3344 4
0 80000010 00000000 F DA5A5A4A 0
0 80000928 00000000 F DA5A5372 8
0 80000128 00000000 F AABB5B72 4
0 10000020 00000000 F 4A5A5A7A 1
0 10000020 00000000 F 4A5A5A7A 1
1 10000020 12345678 1 00000000 1
0 10000020 00000000 F 4A5A5A78 1
0 80800004 00000000 F DADA5A5E 1
0 80000014 00000000 F DA5A3344 0

/* compile.f */
source/dcache_pkg.sv
source/cache_array_if.sv
source/bus_cmd_if.sv
source/cache_store.sv
source/cache_ctrl.sv
source/wb_beat_master.sv
source/dcache_top.sv
testbench/dcache_monitor.sv
testbench/tb_dcache_top.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, then search the log for the failure message
verilator --binary --timing -Wno-fatal --top-module tb_dcache_top -f compile.f -o sim_dcache \
    && ./obj_dir/sim_dcache > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }
cat sim.log
grep -q "ERRORS FOUND" sim.log && { echo "FAIL"; exit 1; } || echo "PASS"
